// ==== logic/lab4_pkg.sv ====
package lab4_pkg;

	////////////////////////////////////////
	// chip array
	////////////////////////////////////////

	// twelve LAB4D chips on the board
	localparam int NUM_LAB = 12;

	// configuration word shifted into one chip
	localparam int SERIAL_BITS = 24;
	localparam int BIT_CNT_W = $clog2(SERIAL_BITS);

	// chip select, NUM_LAB and above is broadcast
	localparam int SEL_W = 4;

	// timing field widths
	localparam int SHIFT_PRESCALE_W = 8;
	localparam int WILK_W = 16;

	////////////////////////////////////////
	// reset defaults
	////////////////////////////////////////

	localparam logic [SHIFT_PRESCALE_W-1:0] SHIFT_PRESCALE_DEFAULT = '0;
	localparam logic [WILK_W-1:0] RAMP_DELAY_DEFAULT = '0;
	localparam logic [WILK_W-1:0] WCLK_STOP_COUNT_DEFAULT = 16'd1024;

	////////////////////////////////////////
	// engine states
	////////////////////////////////////////

	// five states do not fit in two bits
	typedef enum logic [2:0] {
		SER_IDLE,
		SER_SHIFT_HIGH,
		SER_SHIFT_LOW,
		SER_LOAD_HIGH,
		SER_LOAD_LOW
	} serial_state_e;

	typedef enum logic [1:0] {
		RMP_IDLE,
		RMP_DELAY,
		RMP_WCLK_HIGH,
		RMP_WCLK_LOW
	} ramp_state_e;

endpackage

// ==== logic/lab4_regs_pkg.sv ====
package lab4_regs_pkg;

	////////////////////////////////////////
	// bus geometry
	////////////////////////////////////////

	// word index, byte lanes are not decoded
	localparam int ADDR_W = 5;
	localparam int DATA_W = 32;

	typedef enum logic [ADDR_W-1:0] {
		REG_CONTROL        = 5'd0,
		REG_SHIFT_PRESCALE = 5'd1,
		REG_RAMP_DELAY     = 5'd3,
		REG_WCLK_STOP      = 5'd4,
		REG_SERIAL         = 5'd6,
		REG_RAMP           = 5'd7
	} reg_addr_e;

	////////////////////////////////////////
	// field positions
	////////////////////////////////////////

	// control register
	localparam int CTRL_REGCLR_LSB = 16;
	localparam int CTRL_WILK_RESET_BIT = 8;

	// serial register, go on write and busy on read
	localparam int SERIAL_GO_BIT = 31;
	localparam int SERIAL_SEL_LSB = 24;
	localparam int SERIAL_DATA_LSB = 0;

	// ramp register, start on write and pending on read
	localparam int RAMP_START_BIT = 0;

	////////////////////////////////////////
	// transfer structs
	////////////////////////////////////////

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic                                   go;
		logic [lab4_pkg::SEL_W-1:0]             select;
		logic [lab4_pkg::SERIAL_BITS-1:0]       word;
		logic [lab4_pkg::SHIFT_PRESCALE_W-1:0]  prescale;
	} serial_cmd_t;

	typedef struct packed {
		logic                         start;
		logic                         abort;
		logic [lab4_pkg::WILK_W-1:0]  delay;
		logic [lab4_pkg::WILK_W-1:0]  stop_count;
	} ramp_cfg_t;

endpackage

// ==== logic/lab4_reg_bank.sv ====
`timescale 1ns/1ps

module lab4_reg_bank (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  lab4_regs_pkg::bus_req_t       bus_req_i,
	output lab4_regs_pkg::bus_rsp_t       bus_rsp_o,
	input  logic                          serial_busy_i,
	output lab4_regs_pkg::serial_cmd_t    serial_cmd_o,
	input  logic                          ramp_done_i,
	output lab4_regs_pkg::ramp_cfg_t      ramp_cfg_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  regclear_o
);

	lab4_regs_pkg::reg_addr_e addr;
	logic accept;
	logic wr_en;
	logic [lab4_regs_pkg::DATA_W-1:0] wdata;
	logic ack_q;
	logic [lab4_regs_pkg::DATA_W-1:0] rd_mux;
	logic [lab4_regs_pkg::DATA_W-1:0] rdata_q;

	logic [lab4_pkg::NUM_LAB-1:0] regclear_q;
	logic [lab4_pkg::SHIFT_PRESCALE_W-1:0] shift_prescale_q;
	logic [lab4_pkg::WILK_W-1:0] ramp_delay_q;
	logic [lab4_pkg::WILK_W-1:0] wclk_stop_q;
	logic [lab4_pkg::SERIAL_BITS-1:0] serial_word_q;
	logic [lab4_pkg::SEL_W-1:0] serial_select_q;

	logic serial_go_q;
	logic ramp_start_q;
	logic wilk_reset_q;
	logic ramp_pending_q;

	// one transfer per ack, the cycle with ack high never accepts
	assign addr = lab4_regs_pkg::reg_addr_e'(bus_req_i.adr);
	assign wdata = bus_req_i.wdata;
	assign accept = bus_req_i.cyc && bus_req_i.stb && !ack_q;
	assign wr_en = accept && bus_req_i.we;

	////////////////////////////////////////
	// write decode
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			regclear_q <= '0;
			shift_prescale_q <= lab4_pkg::SHIFT_PRESCALE_DEFAULT;
			ramp_delay_q <= lab4_pkg::RAMP_DELAY_DEFAULT;
			wclk_stop_q <= lab4_pkg::WCLK_STOP_COUNT_DEFAULT;
			serial_word_q <= '0;
			serial_select_q <= '0;
			serial_go_q <= 1'b0;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;
		end else begin
			// pulses last one cycle
			serial_go_q <= 1'b0;
			ramp_start_q <= 1'b0;
			wilk_reset_q <= 1'b0;
			if (wr_en) begin
				case (addr)
					lab4_regs_pkg::REG_CONTROL: begin
						regclear_q <= wdata[lab4_regs_pkg::CTRL_REGCLR_LSB +: lab4_pkg::NUM_LAB];
						wilk_reset_q <= wdata[lab4_regs_pkg::CTRL_WILK_RESET_BIT];
					end
					lab4_regs_pkg::REG_SHIFT_PRESCALE:
						shift_prescale_q <= wdata[lab4_pkg::SHIFT_PRESCALE_W-1:0];
					lab4_regs_pkg::REG_RAMP_DELAY:
						ramp_delay_q <= wdata[lab4_pkg::WILK_W-1:0];
					lab4_regs_pkg::REG_WCLK_STOP:
						wclk_stop_q <= wdata[lab4_pkg::WILK_W-1:0];
					lab4_regs_pkg::REG_SERIAL: begin
						serial_word_q <= wdata[lab4_regs_pkg::SERIAL_DATA_LSB +: lab4_pkg::SERIAL_BITS];
						serial_select_q <= wdata[lab4_regs_pkg::SERIAL_SEL_LSB +: lab4_pkg::SEL_W];
						// data is kept even when the writer is busy
						serial_go_q <= wdata[lab4_regs_pkg::SERIAL_GO_BIT] && !serial_busy_i;
					end
					lab4_regs_pkg::REG_RAMP:
						ramp_start_q <= wdata[lab4_regs_pkg::RAMP_START_BIT] && !ramp_pending_q;
					default: ;
				endcase
			end
		end
	end

	// ramp pending, cleared by done or wilkinson reset
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ramp_pending_q <= 1'b0;
		end else if (ramp_done_i || wilk_reset_q) begin
			ramp_pending_q <= 1'b0;
		end else if (ramp_start_q) begin
			ramp_pending_q <= 1'b1;
		end
	end

	////////////////////////////////////////
	// readback
	////////////////////////////////////////

	always_comb begin
		rd_mux = '0;
		case (addr)
			lab4_regs_pkg::REG_CONTROL:
				rd_mux[lab4_regs_pkg::CTRL_REGCLR_LSB +: lab4_pkg::NUM_LAB] = regclear_q;
			lab4_regs_pkg::REG_SHIFT_PRESCALE:
				rd_mux[lab4_pkg::SHIFT_PRESCALE_W-1:0] = shift_prescale_q;
			lab4_regs_pkg::REG_RAMP_DELAY:
				rd_mux[lab4_pkg::WILK_W-1:0] = ramp_delay_q;
			lab4_regs_pkg::REG_WCLK_STOP:
				rd_mux[lab4_pkg::WILK_W-1:0] = wclk_stop_q;
			lab4_regs_pkg::REG_SERIAL: begin
				rd_mux[lab4_regs_pkg::SERIAL_GO_BIT] = serial_busy_i;
				rd_mux[lab4_regs_pkg::SERIAL_SEL_LSB +: lab4_pkg::SEL_W] = serial_select_q;
				rd_mux[lab4_regs_pkg::SERIAL_DATA_LSB +: lab4_pkg::SERIAL_BITS] = serial_word_q;
			end
			lab4_regs_pkg::REG_RAMP:
				rd_mux[lab4_regs_pkg::RAMP_START_BIT] = ramp_pending_q;
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			rdata_q <= rd_mux;
		end
	end

	assign bus_rsp_o.ack = ack_q;
	assign bus_rsp_o.rdata = rdata_q;

	assign serial_cmd_o.go = serial_go_q;
	assign serial_cmd_o.select = serial_select_q;
	assign serial_cmd_o.word = serial_word_q;
	assign serial_cmd_o.prescale = shift_prescale_q;

	assign ramp_cfg_o.start = ramp_start_q;
	assign ramp_cfg_o.abort = wilk_reset_q;
	assign ramp_cfg_o.delay = ramp_delay_q;
	assign ramp_cfg_o.stop_count = wclk_stop_q;

	assign regclear_o = regclear_q;

endmodule

// ==== logic/lab4_serial_writer.sv ====
`timescale 1ns/1ps

module lab4_serial_writer (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  lab4_regs_pkg::serial_cmd_t    cmd_i,
	output logic                          busy_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  sin_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  sclk_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  pclk_o
);

	lab4_pkg::serial_state_e state_q;
	logic [lab4_pkg::SHIFT_PRESCALE_W-1:0] presc_cnt_q;
	logic [lab4_pkg::SHIFT_PRESCALE_W-1:0] prescale_q;
	logic [lab4_pkg::BIT_CNT_W-1:0] bit_cnt_q;
	logic [lab4_pkg::SERIAL_BITS-1:0] shift_q;
	logic [lab4_pkg::NUM_LAB-1:0] sel_mask;
	logic [lab4_pkg::NUM_LAB-1:0] mask_q;
	logic phase_done;
	logic start;
	logic shifting;

	assign start = (state_q == lab4_pkg::SER_IDLE) && cmd_i.go;
	assign phase_done = (presc_cnt_q == '0);

	// select decode, broadcast above the last chip
	always_comb begin
		if (cmd_i.select >= lab4_pkg::SEL_W'(lab4_pkg::NUM_LAB)) begin
			sel_mask = '1;
		end else begin
			sel_mask = lab4_pkg::NUM_LAB'(1) << cmd_i.select;
		end
	end

	// word, chip mask and prescale held for the whole transfer
	always_ff @(posedge clk_i) begin
		if (start) begin
			mask_q <= sel_mask;
			prescale_q <= cmd_i.prescale;
			shift_q <= cmd_i.word;
		end else if (state_q == lab4_pkg::SER_SHIFT_HIGH && phase_done) begin
			shift_q <= shift_q << 1;
		end
	end

	////////////////////////////////////////
	// shift sequencer
	////////////////////////////////////////

	// each bit spends its low phase first so SIN settles before SCLK rises
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= lab4_pkg::SER_IDLE;
			presc_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else begin
			if (state_q != lab4_pkg::SER_IDLE && !phase_done) begin
				presc_cnt_q <= presc_cnt_q - 1'b1;
			end else begin
				presc_cnt_q <= start ? cmd_i.prescale : prescale_q;
			end
			case (state_q)
				lab4_pkg::SER_IDLE: begin
					if (cmd_i.go) begin
						state_q <= lab4_pkg::SER_SHIFT_LOW;
						bit_cnt_q <= lab4_pkg::BIT_CNT_W'(lab4_pkg::SERIAL_BITS - 1);
					end
				end
				lab4_pkg::SER_SHIFT_LOW:
					if (phase_done) state_q <= lab4_pkg::SER_SHIFT_HIGH;
				lab4_pkg::SER_SHIFT_HIGH: begin
					if (phase_done) begin
						if (bit_cnt_q == '0) begin
							state_q <= lab4_pkg::SER_LOAD_HIGH;
						end else begin
							state_q <= lab4_pkg::SER_SHIFT_LOW;
							bit_cnt_q <= bit_cnt_q - 1'b1;
						end
					end
				end
				lab4_pkg::SER_LOAD_HIGH:
					if (phase_done) state_q <= lab4_pkg::SER_LOAD_LOW;
				lab4_pkg::SER_LOAD_LOW:
					if (phase_done) state_q <= lab4_pkg::SER_IDLE;
				default:
					state_q <= lab4_pkg::SER_IDLE;
			endcase
		end
	end

	assign shifting = (state_q == lab4_pkg::SER_SHIFT_LOW) ||
		(state_q == lab4_pkg::SER_SHIFT_HIGH);

	assign busy_o = (state_q != lab4_pkg::SER_IDLE);
	assign sin_o = mask_q & {lab4_pkg::NUM_LAB{shifting && shift_q[lab4_pkg::SERIAL_BITS-1]}};
	assign sclk_o = mask_q & {lab4_pkg::NUM_LAB{state_q == lab4_pkg::SER_SHIFT_HIGH}};
	assign pclk_o = mask_q & {lab4_pkg::NUM_LAB{state_q == lab4_pkg::SER_LOAD_HIGH}};

endmodule

// ==== logic/lab4_wilkinson_ramp.sv ====
`timescale 1ns/1ps

module lab4_wilkinson_ramp (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  lab4_regs_pkg::ramp_cfg_t      cfg_i,
	output logic                          done_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  ramp_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  wclk_p_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  wclk_n_o
);

	lab4_pkg::ramp_state_e state_q;
	logic [lab4_pkg::WILK_W-1:0] dly_cnt_q;
	logic [lab4_pkg::WILK_W-1:0] clk_cnt_q;
	logic done_q;

	////////////////////////////////////////
	// ramp sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= lab4_pkg::RMP_IDLE;
			dly_cnt_q <= '0;
			clk_cnt_q <= '0;
			done_q <= 1'b0;
		end else if (cfg_i.abort) begin
			// wilkinson reset drops everything at once
			state_q <= lab4_pkg::RMP_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				lab4_pkg::RMP_IDLE: begin
					if (cfg_i.start) begin
						dly_cnt_q <= cfg_i.delay - lab4_pkg::WILK_W'(1);
						clk_cnt_q <= cfg_i.stop_count;
						// zero delay starts the clock with the ramp
						if (cfg_i.delay == '0) begin
							state_q <= lab4_pkg::RMP_WCLK_HIGH;
						end else begin
							state_q <= lab4_pkg::RMP_DELAY;
						end
					end
				end
				lab4_pkg::RMP_DELAY: begin
					if (dly_cnt_q == '0) begin
						state_q <= lab4_pkg::RMP_WCLK_HIGH;
					end else begin
						dly_cnt_q <= dly_cnt_q - 1'b1;
					end
				end
				lab4_pkg::RMP_WCLK_HIGH:
					state_q <= lab4_pkg::RMP_WCLK_LOW;
				lab4_pkg::RMP_WCLK_LOW: begin
					// last low phase ends the ramp
					if (clk_cnt_q <= lab4_pkg::WILK_W'(1)) begin
						state_q <= lab4_pkg::RMP_IDLE;
						done_q <= 1'b1;
					end else begin
						clk_cnt_q <= clk_cnt_q - 1'b1;
						state_q <= lab4_pkg::RMP_WCLK_HIGH;
					end
				end
				default:
					state_q <= lab4_pkg::RMP_IDLE;
			endcase
		end
	end

	// all chips ramp and count together
	assign ramp_o = {lab4_pkg::NUM_LAB{state_q != lab4_pkg::RMP_IDLE}};
	assign wclk_p_o = {lab4_pkg::NUM_LAB{state_q == lab4_pkg::RMP_WCLK_HIGH}};
	assign wclk_n_o = {lab4_pkg::NUM_LAB{state_q == lab4_pkg::RMP_WCLK_LOW}};
	assign done_o = done_q;

endmodule

// ==== logic/lab4_controller.sv ====
`timescale 1ns/1ps

module lab4_controller (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  lab4_regs_pkg::bus_req_t       bus_req_i,
	output lab4_regs_pkg::bus_rsp_t       bus_rsp_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  SIN_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  SCLK_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  PCLK_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  REGCLR_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  RAMP_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  WCLK_P_o,
	output logic [lab4_pkg::NUM_LAB-1:0]  WCLK_N_o
);

	lab4_regs_pkg::serial_cmd_t serial_cmd;
	lab4_regs_pkg::ramp_cfg_t ramp_cfg;
	logic serial_busy;
	logic ramp_done;

	// bus registers, REGCLR comes straight from control
	lab4_reg_bank u_reg_bank (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.bus_req_i     (bus_req_i),
		.bus_rsp_o     (bus_rsp_o),
		.serial_busy_i (serial_busy),
		.serial_cmd_o  (serial_cmd),
		.ramp_done_i   (ramp_done),
		.ramp_cfg_o    (ramp_cfg),
		.regclear_o    (REGCLR_o)
	);

	lab4_serial_writer u_serial_writer (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.cmd_i   (serial_cmd),
		.busy_o  (serial_busy),
		.sin_o   (SIN_o),
		.sclk_o  (SCLK_o),
		.pclk_o  (PCLK_o)
	);

	lab4_wilkinson_ramp u_ramp (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.cfg_i    (ramp_cfg),
		.done_o   (ramp_done),
		.ramp_o   (RAMP_o),
		.wclk_p_o (WCLK_P_o),
		.wclk_n_o (WCLK_N_o)
	);

endmodule

// ==== test/lab4_controller_tb.sv ====
`timescale 1ns/1ps

module lab4_controller_tb;

	localparam int MAX_P = 4;
	localparam int TAIL_CYCLES = 24;
	localparam int ACK_LIMIT = 8;
	localparam int ABORT_STOP = 200;
	// worst-case lengths in clock cycles
	localparam int SERIAL_WORST = 50 * MAX_P + TAIL_CYCLES;
	localparam int RAMP_WORST = 7 + 2 * 11 + 20;
	localparam int ABORT_WORST = 3 + 2 * ABORT_STOP;
	localparam int BUS_WORST = 80 * 4;
	localparam int WATCHDOG_CYCLES =
		2 * (2 * SERIAL_WORST + RAMP_WORST + ABORT_WORST + BUS_WORST + 10) + 500;

	logic clk_i;
	logic reset_i;
	lab4_regs_pkg::bus_req_t bus_req;
	lab4_regs_pkg::bus_rsp_t bus_rsp;
	logic [lab4_pkg::NUM_LAB-1:0] sin;
	logic [lab4_pkg::NUM_LAB-1:0] sclk;
	logic [lab4_pkg::NUM_LAB-1:0] pclk;
	logic [lab4_pkg::NUM_LAB-1:0] regclr;
	logic [lab4_pkg::NUM_LAB-1:0] ramp;
	logic [lab4_pkg::NUM_LAB-1:0] wclk_p;
	logic [lab4_pkg::NUM_LAB-1:0] wclk_n;
	int seed;

	lab4_controller uut (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.SIN_o     (sin),
		.SCLK_o    (sclk),
		.PCLK_o    (pclk),
		.REGCLR_o  (regclr),
		.RAMP_o    (ramp),
		.WCLK_P_o  (wclk_p),
		.WCLK_N_o  (wclk_n)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual) else begin
			$display("TESTBENCH FAILED");
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_with_reason(input string reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "%s", reason);
	endtask

	function automatic int pick_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		stop_with_reason("watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// bus master
	////////////////////////////////////////

	task automatic bus_transfer(input logic we, input logic [4:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(posedge clk_i);
		bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, wdata: wdata};
		// accepted at the next edge, ack one cycle after that
		@(negedge clk_i);
		check_value("bus_rsp.ack before acceptance", 0, bus_rsp.ack);
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!bus_rsp.ack && waited < ACK_LIMIT);
		if (!bus_rsp.ack) begin
			stop_with_reason("the bus never acknowledged a request");
		end
		check_value("bus_rsp.ack latency", 1, waited);
		rdata = bus_rsp.rdata;
		@(posedge clk_i);
		bus_req <= '0;
	endtask

	task automatic bus_write(input logic [4:0] adr, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_transfer(1'b1, adr, wdata, unused);
	endtask

	task automatic bus_read(input logic [4:0] adr, output logic [31:0] rdata);
		bus_transfer(1'b0, adr, '0, rdata);
	endtask

	task automatic write_and_compare(input logic [4:0] adr, input logic [31:0] wdata,
			input logic [31:0] mask, input string name);
		logic [31:0] value;
		bus_write(adr, wdata);
		bus_read(adr, value);
		check_value(name, wdata & mask, value);
	endtask

	////////////////////////////////////////
	// reset and register tests
	////////////////////////////////////////

	task automatic check_reset_state();
		logic [4:0] zero_regs [7];
		logic [31:0] value;
		zero_regs = '{lab4_regs_pkg::REG_CONTROL, lab4_regs_pkg::REG_SHIFT_PRESCALE,
			lab4_regs_pkg::REG_RAMP_DELAY, lab4_regs_pkg::REG_SERIAL,
			lab4_regs_pkg::REG_RAMP, 5'd2, 5'd31};
		@(negedge clk_i);
		check_value("bus_rsp.ack", 0, bus_rsp.ack);
		check_value("serial busy", 0, uut.serial_busy);
		check_value("SIN_o", 0, sin);
		check_value("SCLK_o", 0, sclk);
		check_value("PCLK_o", 0, pclk);
		check_value("REGCLR_o", 0, regclr);
		check_value("RAMP_o", 0, ramp);
		check_value("WCLK_P_o", 0, wclk_p);
		check_value("WCLK_N_o", 0, wclk_n);
		bus_read(lab4_regs_pkg::REG_WCLK_STOP, value);
		check_value("wclk stop count after reset", 1024, value);
		for (int i = 0; i < 7; i++) begin
			bus_read(zero_regs[i], value);
			check_value("register after reset", 0, value);
		end
	endtask

	task automatic check_readback();
		logic [31:0] data;
		for (int i = 0; i < 4; i++) begin
			// wilkinson reset bit set on purpose, it must read back as zero
			data = $random(seed) | (32'h1 << lab4_regs_pkg::CTRL_WILK_RESET_BIT);
			write_and_compare(lab4_regs_pkg::REG_CONTROL, data, 32'h0fff_0000,
				"control readback");
			@(negedge clk_i);
			check_value("REGCLR_o", data[27:16], regclr);
			write_and_compare(lab4_regs_pkg::REG_SHIFT_PRESCALE, $random(seed),
				32'h0000_00ff, "prescale readback");
			write_and_compare(lab4_regs_pkg::REG_RAMP_DELAY, $random(seed),
				32'h0000_ffff, "ramp delay readback");
			write_and_compare(lab4_regs_pkg::REG_WCLK_STOP, $random(seed),
				32'h0000_ffff, "wclk stop readback");
			write_and_compare(lab4_regs_pkg::REG_SERIAL, $random(seed) & 32'h7fff_ffff,
				32'h0fff_ffff, "serial readback");
		end
	endtask

	////////////////////////////////////////
	// serial writer
	////////////////////////////////////////

	task automatic watch_serial(input int p, input logic [11:0] mask, input logic [23:0] word);
		logic [11:0] sclk_prev;
		logic [11:0] pclk_prev;
		logic [11:0] sin_prev;
		logic [11:0] quiet;
		logic [23:0] got [12];
		int sclk_rises [12];
		int pclk_rises [12];
		int busy_cycles;
		int busy_starts;
		logic busy_prev;
		sclk_prev = '0;
		pclk_prev = '0;
		sin_prev = '0;
		busy_cycles = 0;
		busy_starts = 0;
		busy_prev = 1'b0;
		for (int c = 0; c < 12; c++) begin
			got[c] = '0;
			sclk_rises[c] = 0;
			pclk_rises[c] = 0;
		end
		// window holds the whole shift and a quiet tail
		for (int n = 0; n < 50 * p + TAIL_CYCLES; n++) begin
			@(negedge clk_i);
			if (uut.serial_busy) busy_cycles++;
			if (uut.serial_busy && !busy_prev) busy_starts++;
			busy_prev = uut.serial_busy;
			quiet = (sin | sclk | pclk) & ~mask;
			check_value("unselected chip outputs", 0, quiet);
			for (int c = 0; c < 12; c++) begin
				if (sclk[c] && !sclk_prev[c]) begin
					check_value("SIN_o across SCLK_o rise", sin_prev[c], sin[c]);
					got[c] = {got[c][22:0], sin[c]};
					sclk_rises[c]++;
				end
				if (pclk[c] && !pclk_prev[c]) begin
					check_value("SCLK_o rises before PCLK_o", 24, sclk_rises[c]);
					pclk_rises[c]++;
				end
			end
			sclk_prev = sclk;
			pclk_prev = pclk;
			sin_prev = sin;
		end
		check_value("serial busy cycles", 50 * p, busy_cycles);
		check_value("serial shifts started", 1, busy_starts);
		for (int c = 0; c < 12; c++) begin
			if (mask[c]) begin
				check_value("SCLK_o rising edges", 24, sclk_rises[c]);
				check_value("PCLK_o pulses", 1, pclk_rises[c]);
				check_value("SIN_o word", word, got[c]);
			end
		end
	endtask

	task automatic run_serial(input int p, input logic [3:0] sel, input logic [23:0] word,
			input logic second_go);
		logic [11:0] mask;
		logic [31:0] value;
		mask = (sel >= 4'd12) ? 12'hfff : (12'h1 << sel);
		bus_write(lab4_regs_pkg::REG_SHIFT_PRESCALE, p - 1);
		fork
			watch_serial(p, mask, word);
			begin
				bus_write(lab4_regs_pkg::REG_SERIAL, {1'b1, 3'b0, sel, word});
				bus_read(lab4_regs_pkg::REG_SERIAL, value);
				check_value("serial busy bit during shift", 1, value[31]);
				check_value("serial data during shift", {sel, word}, value[27:0]);
				if (second_go) begin
					// stored but not started while busy
					bus_write(lab4_regs_pkg::REG_SERIAL, {1'b1, 3'b0, sel, ~word});
					bus_read(lab4_regs_pkg::REG_SERIAL, value);
					check_value("serial data written while busy", {sel, ~word}, value[27:0]);
				end
			end
		join
		bus_read(lab4_regs_pkg::REG_SERIAL, value);
		check_value("serial busy bit after shift", 0, value[31]);
	endtask

	////////////////////////////////////////
	// wilkinson ramp
	////////////////////////////////////////

	task automatic watch_ramp(input int delay, input int stop);
		logic [11:0] wclk_prev;
		logic [11:0] wclk_n_exp;
		logic ramp_seen;
		logic finished;
		int cycles;
		int ramp_rise_at;
		int first_wclk_at;
		int wclk_rises;
		wclk_prev = '0;
		ramp_seen = 1'b0;
		finished = 1'b0;
		cycles = 0;
		ramp_rise_at = 0;
		first_wclk_at = 0;
		wclk_rises = 0;
		while (!finished && cycles < delay + 2 * stop + 20) begin
			@(negedge clk_i);
			cycles++;
			check_value("RAMP_o lines", {12{ramp[0]}}, ramp);
			check_value("WCLK_P_o lines", {12{wclk_p[0]}}, wclk_p);
			if (!ramp_seen && ramp[0]) begin
				ramp_seen = 1'b1;
				ramp_rise_at = cycles;
			end
			if (wclk_p[0] && !wclk_prev[0]) begin
				if (wclk_rises == 0) first_wclk_at = cycles;
				wclk_rises++;
			end
			wclk_n_exp = ~wclk_p;
			if (ramp[0] && wclk_rises > 0) check_value("WCLK_N_o", wclk_n_exp, wclk_n);
			if (ramp_seen && !ramp[0]) begin
				finished = 1'b1;
				check_value("WCLK_P_o after RAMP_o falls", 0, wclk_p);
			end
			wclk_prev = wclk_p;
		end
		if (!finished) begin
			stop_with_reason("RAMP_o did not rise and fall in time");
		end
		check_value("WCLK_P_o rising edges", stop, wclk_rises);
		check_value("WCLK_P_o delay after RAMP_o", delay, first_wclk_at - ramp_rise_at);
	endtask

	task automatic run_ramp(input int delay, input int stop);
		logic [31:0] value;
		bus_write(lab4_regs_pkg::REG_RAMP_DELAY, delay);
		bus_write(lab4_regs_pkg::REG_WCLK_STOP, stop);
		fork
			watch_ramp(delay, stop);
			begin
				bus_write(lab4_regs_pkg::REG_RAMP, 32'h1);
				bus_read(lab4_regs_pkg::REG_RAMP, value);
				check_value("ramp pending during ramp", 1, value[0]);
			end
		join
		bus_read(lab4_regs_pkg::REG_RAMP, value);
		check_value("ramp pending after ramp", 0, value[0]);
	endtask

	task automatic run_abort();
		logic [31:0] value;
		int waited;
		bus_write(lab4_regs_pkg::REG_RAMP_DELAY, pick_below(4));
		bus_write(lab4_regs_pkg::REG_WCLK_STOP, ABORT_STOP);
		bus_write(lab4_regs_pkg::REG_RAMP, 32'h1);
		waited = 0;
		do begin
			@(negedge clk_i);
			waited++;
		end while (!ramp[0] && waited < 8);
		if (!ramp[0]) begin
			stop_with_reason("RAMP_o never rose before the abort");
		end
		repeat (1 + pick_below(6)) @(posedge clk_i);
		bus_write(lab4_regs_pkg::REG_CONTROL, 32'h1 << lab4_regs_pkg::CTRL_WILK_RESET_BIT);
		@(negedge clk_i);
		check_value("RAMP_o after abort", 0, ramp);
		check_value("WCLK_P_o after abort", 0, wclk_p);
		check_value("WCLK_N_o after abort", 0, wclk_n);
		bus_read(lab4_regs_pkg::REG_RAMP, value);
		check_value("ramp pending after abort", 0, value[0]);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		seed = 32'h82a9;
		reset_i = 1'b1;
		bus_req = '0;
		repeat (10) @(posedge clk_i);
		reset_i <= 1'b0;
		check_reset_state();
		check_readback();
		run_serial(1 + pick_below(MAX_P), 4'(pick_below(12)), 24'($random(seed)), 1'b0);
		run_serial(1 + pick_below(MAX_P), 4'(12 + pick_below(4)), 24'($random(seed)), 1'b1);
		run_ramp(pick_below(8), 4 + pick_below(8));
		run_abort();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== lab4_controller.f ====
logic/lab4_pkg.sv
logic/lab4_regs_pkg.sv
logic/lab4_reg_bank.sv
logic/lab4_serial_writer.sv
logic/lab4_wilkinson_ramp.sv
logic/lab4_controller.sv
test/lab4_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator and runs it, the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lab4_controller_tb \
	-f lab4_controller.f --Mdir obj_dir -o lab4_sim \
	&& ./obj_dir/lab4_sim \
	|| { echo "simulation failed"; exit 1; }
